//--- Bender.yml
package:
  name: axil_mem

sources:
  - files:
      - verilog/axil_mem_pkg.sv
      - verilog/axil_skid_buffer.sv
      - verilog/axil_mem_ram.sv
      - verilog/axil_mem_write.sv
      - verilog/axil_mem_read.sv
      - verilog/axil_mem_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/axil_mem_tb.sv

//--- tb/axil_mem_tb_tasks.svh
/* Channel driver tasks with timeouts, response drain waits
   and the per-test report helpers */

    // Ends the run when a channel stops moving
    task automatic report_timeout(input string chan);
        $display("Timeout: the %s channel stopped moving during test %s", chan, test_name);
        $display("TEST FAIL");
        $finish;
    endtask

    // Holds until the channel's ready is seen on a rising edge
    task automatic wait_ready(input string chan);
        int cnt;
        cnt = 0;
        do begin
            @(posedge aclk);
            cnt++;
            if (cnt > TIMEOUT) begin
                report_timeout(chan);
            end
        end while (!((chan == "AW") ? s_axil_awready :
                     (chan == "W")  ? s_axil_wready : s_axil_arready));
    endtask

    task automatic send_aw(input axil_mem_pkg::axil_ax_t a);
        @(negedge aclk);
        s_axil_aw      = a;
        s_axil_awvalid = 1'b1;
        wait_ready("AW");
        @(negedge aclk);
        s_axil_awvalid = 1'b0;
    endtask

    task automatic send_w(input axil_mem_pkg::axil_w_t wd);
        @(negedge aclk);
        s_axil_w      = wd;
        s_axil_wvalid = 1'b1;
        wait_ready("W");
        @(negedge aclk);
        s_axil_wvalid = 1'b0;
    endtask

    task automatic send_ar(input axil_mem_pkg::axil_ax_t a);
        @(negedge aclk);
        s_axil_ar      = a;
        s_axil_arvalid = 1'b1;
        wait_ready("AR");
        @(negedge aclk);
        s_axil_arvalid = 1'b0;
    endtask

    // Waits until the checker has seen every expected response
    task automatic wait_drain(input string chan);
        int cnt;
        cnt = 0;
        while (exp_b.size() != 0 || exp_r.size() != 0) begin
            @(negedge aclk);
            cnt++;
            if (cnt > TIMEOUT) begin
                report_timeout(chan);
            end
        end
    endtask

    task automatic wait_rvalid();
        int cnt;
        cnt = 0;
        do begin
            @(posedge aclk);
            cnt++;
            if (cnt > TIMEOUT) begin
                report_timeout("R");
            end
        end while (!s_axil_rvalid);
    endtask

    // Order 0 sends AW first, 1 sends W first, anything else both at once
    task automatic write_txn(input axil_mem_pkg::axil_ax_t a, input axil_mem_pkg::axil_w_t wd,
                             input logic [1:0] order);
        axil_mem_pkg::axil_r_t            ref_r;
        axil_mem_pkg::axil_b_t            ref_b;
        logic [axil_mem_pkg::WORD_AW-1:0] idx;
        ref_r      = expected_read(a.addr);
        ref_b.resp = ref_r.resp;              // Same range rule as a read
        exp_b.push_back(ref_b);
        idx = a.addr[axil_mem_pkg::BYTE_OFS +: axil_mem_pkg::WORD_AW];
        if (ref_r.resp == axil_mem_pkg::RESP_OKAY) begin
            shadow[idx] = merge_bytes(shadow[idx], wd.data, wd.strb);
        end
        case (order)
            2'd0: begin
                send_aw(a);
                send_w(wd);
            end
            2'd1: begin
                send_w(wd);
                send_aw(a);
            end
            default: begin
                fork
                    send_aw(a);
                    send_w(wd);
                join
            end
        endcase
        wait_drain("B");
    endtask

    task automatic read_txn(input axil_mem_pkg::axil_ax_t a, input logic drain);
        exp_r.push_back(expected_read(a.addr));
        send_ar(a);
        if (drain) begin
            wait_drain("R");
        end
    endtask

    task automatic report_test();
        if (test_errs == 0) begin
            pass_count++;
            $display("%s: passed", test_name);
        end else begin
            fail_count++;
            $display("%s: failed with %0d errors", test_name, test_errs);
        end
        test_errs = 0;
    endtask

//--- tb/axil_mem_tb.sv
/* Testbench for the AXI4-Lite slave memory with LFSR stimulus,
   a shadow reference model and a response checker */

`default_nettype none

module axil_mem_tb;

    localparam logic [31:0] SEED     = 32'hd20bf24a;
    localparam int          TIMEOUT  = 500;  // Cycles allowed per wait
    localparam int          WORDS    = 16;   // Words exercised by the tests
    localparam int          MIX_RUNS = 40;

    logic                   aclk;
    logic                   aresetn;
    axil_mem_pkg::axil_ax_t s_axil_aw;
    logic                   s_axil_awvalid;
    logic                   s_axil_awready;
    axil_mem_pkg::axil_w_t  s_axil_w;
    logic                   s_axil_wvalid;
    logic                   s_axil_wready;
    axil_mem_pkg::axil_b_t  s_axil_b;
    logic                   s_axil_bvalid;
    logic                   s_axil_bready;
    axil_mem_pkg::axil_ax_t s_axil_ar;
    logic                   s_axil_arvalid;
    logic                   s_axil_arready;
    axil_mem_pkg::axil_r_t  s_axil_r;
    logic                   s_axil_rvalid;
    logic                   s_axil_rready;

    // Reference model and checker state
    logic [axil_mem_pkg::DATA_WIDTH-1:0] shadow [axil_mem_pkg::MEM_DEPTH];
    axil_mem_pkg::axil_b_t exp_b [$];
    axil_mem_pkg::axil_r_t exp_r [$];
    axil_mem_pkg::axil_b_t b_front;
    axil_mem_pkg::axil_r_t r_front;
    axil_mem_pkg::axil_r_t held_r;     // R payload seen while stalled
    logic                  r_held;
    logic [31:0]           lfsr_st;
    logic [31:0]           ready_st;   // Own stream for ready patterns
    logic                  rand_ready;
    logic                  hold_rready;
    string                 test_name;
    int                    test_errs;
    int                    pass_count;
    int                    fail_count;

    always #50 aclk = ~aclk;

    axil_mem_top dut_i (.*);

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v       = {v[30:0], lfsr_st[0]};  // One step per bit
            lfsr_st = galois_step(lfsr_st);
        end
        return v;
    endfunction

    // Strobed bytes replace the old ones
    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0]  strb);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[i*8 +: 8] = data[i*8 +: 8];
            end
        end
        return res;
    endfunction

    // Expected response and data for a read of this address
    function automatic axil_mem_pkg::axil_r_t expected_read(input logic [31:0] addr);
        axil_mem_pkg::axil_r_t res;
        if ((addr >> axil_mem_pkg::BYTE_OFS) >= axil_mem_pkg::MEM_DEPTH) begin
            res.data = '0;
            res.resp = axil_mem_pkg::RESP_SLVERR;
        end else begin
            res.data = shadow[addr[axil_mem_pkg::BYTE_OFS +: axil_mem_pkg::WORD_AW]];
            res.resp = axil_mem_pkg::RESP_OKAY;
        end
        return res;
    endfunction

    function automatic axil_mem_pkg::axil_ax_t rand_ax(input logic [31:0] word);
        axil_mem_pkg::axil_ax_t a;
        a.addr = word << axil_mem_pkg::BYTE_OFS;
        a.prot = rand_bits(3);
        return a;
    endfunction

    function automatic axil_mem_pkg::axil_w_t rand_w(input logic full);
        axil_mem_pkg::axil_w_t wd;
        wd.data = rand_bits(32);
        wd.strb = full ? 4'hf : rand_bits(4);
        return wd;
    endfunction

    `include "axil_mem_tb_tasks.svh"

    // Ready patterns for B and R
    always @(negedge aclk) begin
        if (rand_ready) begin
            s_axil_bready = ready_st[0];
            ready_st      = galois_step(ready_st);
            s_axil_rready = ~hold_rready & ready_st[0];
            ready_st      = galois_step(ready_st);
        end else begin
            s_axil_bready = 1'b1;
            s_axil_rready = ~hold_rready;
        end
    end

    // Compares every B and R transfer with the expected queues
    always @(posedge aclk) begin
        if (aresetn) begin
            if (s_axil_bvalid && s_axil_bready) begin
                assert (exp_b.size() > 0) else begin
                    $display("In test %s a write response came with no write waiting", test_name);
                    test_errs++;
                end
                if (exp_b.size() > 0) begin
                    b_front = exp_b.pop_front();
                    assert (s_axil_b === b_front) else begin
                        $display("Error %s: bresp expected %0h, actual %0h", test_name,
                                 b_front.resp, s_axil_b.resp);
                        test_errs++;
                    end
                end
            end
            if (s_axil_rvalid && s_axil_rready) begin
                assert (exp_r.size() > 0) else begin
                    $display("In test %s a read response came with no read waiting", test_name);
                    test_errs++;
                end
                if (exp_r.size() > 0) begin
                    r_front = exp_r.pop_front();
                    assert (s_axil_r === r_front) else begin
                        $display("Error %s: rdata/rresp expected %h/%0h, actual %h/%0h",
                                 test_name, r_front.data, r_front.resp,
                                 s_axil_r.data, s_axil_r.resp);
                        test_errs++;
                    end
                end
            end
            assert (!r_held || (s_axil_rvalid && s_axil_r === held_r)) else begin
                $display("In test %s the R channel changed while rready was low", test_name);
                test_errs++;
            end
            r_held = s_axil_rvalid && !s_axil_rready;
            held_r = s_axil_r;
        end
    end

    initial begin
        axil_mem_pkg::axil_ax_t a;
        axil_mem_pkg::axil_w_t  wd;
        logic [31:0]            word;
        logic [31:0]            idx;
        aclk           = 1'b0;
        aresetn        = 1'b0;
        s_axil_aw      = '0;
        s_axil_awvalid = 1'b0;
        s_axil_w       = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b1;
        s_axil_ar      = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b1;
        lfsr_st        = SEED;
        ready_st       = SEED;
        rand_ready     = 1'b0;
        hold_rready    = 1'b0;
        r_held         = 1'b0;
        test_errs      = 0;
        pass_count     = 0;
        fail_count     = 0;
        repeat (3) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;

        test_name = "reset";
        assert (!s_axil_bvalid && !s_axil_rvalid) else begin
            $display("Error %s: bvalid/rvalid expected 0/0, actual %0b/%0b", test_name,
                     s_axil_bvalid, s_axil_rvalid);
            test_errs++;
        end
        assert (s_axil_awready && s_axil_wready && s_axil_arready) else begin
            $display("Error %s: aw/w/ar ready expected 111, actual %b%b%b", test_name,
                     s_axil_awready, s_axil_wready, s_axil_arready);
            test_errs++;
        end
        report_test();

        test_name = "full_writes";
        for (int i = 0; i < WORDS; i++) begin
            a  = rand_ax(i);
            wd = rand_w(1'b1);
            write_txn(a, wd, rand_bits(2));
        end
        for (int i = 0; i < WORDS; i++) begin
            a = rand_ax(i);
            read_txn(a, 1'b1);
        end
        report_test();

        test_name = "partial_strobes";
        for (int i = 0; i < 12; i++) begin
            a  = rand_ax(rand_bits(4));
            wd = rand_w(1'b0);
            write_txn(a, wd, rand_bits(2));
            read_txn(a, 1'b1);
        end
        report_test();

        test_name = "out_of_range";
        for (int i = 0; i < 4; i++) begin
            idx  = rand_bits(4);
            word = axil_mem_pkg::MEM_DEPTH * (1 + rand_bits(2)) + idx;
            a    = rand_ax(word);
            wd   = rand_w(1'b1);
            write_txn(a, wd, 2'd2);
            read_txn(a, 1'b1);
            a = rand_ax(idx);      // Aliased low word must be untouched
            read_txn(a, 1'b1);
        end
        report_test();

        test_name = "random_mix";
        @(posedge aclk);
        rand_ready = 1'b1;
        for (int i = 0; i < MIX_RUNS; i++) begin
            word = rand_bits(4);
            if (rand_bits(3) == 0) begin
                word = word + axil_mem_pkg::MEM_DEPTH;
            end
            a = rand_ax(word);
            if (rand_bits(1)) begin
                wd = rand_w(1'b0);
                write_txn(a, wd, rand_bits(2));
            end else begin
                read_txn(a, 1'b1);
            end
        end
        @(posedge aclk);
        rand_ready = 1'b0;
        report_test();

        test_name = "stalled_reads";
        @(posedge aclk);
        hold_rready = 1'b1;
        for (int i = 0; i < 3; i++) begin
            a = rand_ax(rand_bits(4));
            read_txn(a, 1'b0);
        end
        wait_rvalid();
        hold_rready = 1'b0;
        wait_drain("R");
        repeat (4) @(negedge aclk);  // Room for a duplicated response to show up
        report_test();

        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && test_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+tb
verilog/axil_mem_pkg.sv
verilog/axil_skid_buffer.sv
verilog/axil_mem_ram.sv
verilog/axil_mem_write.sv
verilog/axil_mem_read.sv
verilog/axil_mem_top.sv
tb/axil_mem_tb.sv

//--- verilog/axil_mem_pkg.sv
/* Shared widths, memory depth, AXI-Lite response codes and the
   packed channel structs used by the AXI-Lite slave memory */

`default_nettype none

package axil_mem_pkg;

    // Bus geometry
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;  // One strobe per byte

    // Memory geometry
    localparam int MEM_DEPTH  = 1024;            // Words
    localparam int WORD_AW    = 10;              // log2 of MEM_DEPTH
    localparam int BYTE_OFS   = 2;               // Byte offset bits inside a word

    // Response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Address channel payload, same layout for AW and AR
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [2:0]            prot;  // Carried along but never interpreted
    } axil_ax_t;

    // Write data channel payload
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
    } axil_w_t;

    // Write response channel payload
    typedef struct packed {
        logic [1:0] resp;
    } axil_b_t;

    // Read data channel payload
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [1:0]            resp;
    } axil_r_t;

    // RAM write port, driven by the write unit
    typedef struct packed {
        logic [WORD_AW-1:0]    idx;   // Word index
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] be;    // Byte enables
    } ram_wr_t;

endpackage

`default_nettype wire

//--- verilog/axil_mem_ram.sv
/* Single-clock word RAM with a byte-enabled write port
   and a registered read port */

`default_nettype none

module axil_mem_ram (
    input  wire logic                               aclk,

    input  wire logic                               ram_we,
    input  wire axil_mem_pkg::ram_wr_t              ram_wr,

    input  wire logic                               ram_re,
    input  wire logic [axil_mem_pkg::WORD_AW-1:0]   ram_rd_idx,
    output logic [axil_mem_pkg::DATA_WIDTH-1:0]     ram_rdata
);

    // Storage array, contents undefined until written
    logic [axil_mem_pkg::DATA_WIDTH-1:0] mem [axil_mem_pkg::MEM_DEPTH];

    // Write port, only enabled bytes change
    always_ff @(posedge aclk) begin
        if (ram_we) begin
            for (int i = 0; i < axil_mem_pkg::STRB_WIDTH; i++) begin
                if (ram_wr.be[i]) begin
                    mem[ram_wr.idx][i*8 +: 8] <= ram_wr.data[i*8 +: 8];
                end
            end
        end
    end

    // Read port, old contents win on a same-cycle collision
    always_ff @(posedge aclk) begin
        if (ram_re) begin
            ram_rdata <= mem[ram_rd_idx];  // Held until the next ram_re
        end
    end

endmodule

`default_nettype wire

//--- verilog/axil_mem_read.sv
/* Read unit: accepts AR, issues the RAM read and holds the
   R response, with zero data and SLVERR out of range */

`default_nettype none

module axil_mem_read (
    input  wire logic                               aclk,
    input  wire logic                               aresetn,

    input  wire axil_mem_pkg::axil_ax_t             ar,
    input  wire logic                               ar_valid,
    output logic                                    ar_ready,

    output axil_mem_pkg::axil_r_t                   r,
    output logic                                    r_valid,
    input  wire logic                               r_ready,

    output logic                                    ram_re,
    output logic [axil_mem_pkg::WORD_AW-1:0]        ram_rd_idx,
    input  wire logic [axil_mem_pkg::DATA_WIDTH-1:0] ram_rdata
);

    localparam int WORD_BITS = axil_mem_pkg::ADDR_WIDTH - axil_mem_pkg::BYTE_OFS;

    logic [WORD_BITS-1:0] word_addr;
    logic                 in_range;
    logic                 accept;
    logic                 pending;   // Read sitting in the RAM stage
    logic                 pend_ok;   // Its range check result

    assign word_addr = ar.addr[axil_mem_pkg::ADDR_WIDTH-1:axil_mem_pkg::BYTE_OFS];
    assign in_range  = (word_addr < WORD_BITS'(axil_mem_pkg::MEM_DEPTH));

    // One read in flight, response register must be free by load time
    assign ar_ready = ~pending & (~r_valid | r_ready);
    assign accept   = ar_valid & ar_ready;

    assign ram_re     = accept;
    assign ram_rd_idx = ar.addr[axil_mem_pkg::BYTE_OFS +: axil_mem_pkg::WORD_AW];

    // Control state
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            pending <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            pending <= accept;
            if (pending) begin
                r_valid <= 1'b1;        // RAM data is ready now
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    // Range flag travels with the pending read
    always_ff @(posedge aclk) begin
        if (accept) begin
            pend_ok <= in_range;
        end
    end

    // Response payload, held while rready is low
    always_ff @(posedge aclk) begin
        if (pending) begin
            if (pend_ok) begin
                r.data <= ram_rdata;
                r.resp <= axil_mem_pkg::RESP_OKAY;
            end else begin
                r.data <= '0;
                r.resp <= axil_mem_pkg::RESP_SLVERR;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/axil_mem_top.sv
/* AXI4-Lite slave memory top: request skid buffers,
   write unit, read unit and the word RAM */

`default_nettype none

module axil_mem_top (
    input  wire logic                   aclk,
    input  wire logic                   aresetn,

    input  wire axil_mem_pkg::axil_ax_t s_axil_aw,
    input  wire logic                   s_axil_awvalid,
    output logic                        s_axil_awready,

    input  wire axil_mem_pkg::axil_w_t  s_axil_w,
    input  wire logic                   s_axil_wvalid,
    output logic                        s_axil_wready,

    output axil_mem_pkg::axil_b_t       s_axil_b,
    output logic                        s_axil_bvalid,
    input  wire logic                   s_axil_bready,

    input  wire axil_mem_pkg::axil_ax_t s_axil_ar,
    input  wire logic                   s_axil_arvalid,
    output logic                        s_axil_arready,

    output axil_mem_pkg::axil_r_t       s_axil_r,
    output logic                        s_axil_rvalid,
    input  wire logic                   s_axil_rready
);

    // Skid buffer outputs toward the units
    axil_mem_pkg::axil_ax_t aw_q;
    logic                   aw_q_valid;
    logic                   aw_q_ready;
    axil_mem_pkg::axil_w_t  w_q;
    logic                   w_q_valid;
    logic                   w_q_ready;
    axil_mem_pkg::axil_ax_t ar_q;
    logic                   ar_q_valid;
    logic                   ar_q_ready;

    // RAM ports
    logic                                ram_we;
    axil_mem_pkg::ram_wr_t               ram_wr;
    logic                                ram_re;
    logic [axil_mem_pkg::WORD_AW-1:0]    ram_rd_idx;
    logic [axil_mem_pkg::DATA_WIDTH-1:0] ram_rdata;

    axil_skid_buffer #(.payload_t(axil_mem_pkg::axil_ax_t)) aw_skid_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_data   (s_axil_aw),
        .in_valid  (s_axil_awvalid),
        .in_ready  (s_axil_awready),
        .out_data  (aw_q),
        .out_valid (aw_q_valid),
        .out_ready (aw_q_ready)
    );

    axil_skid_buffer #(.payload_t(axil_mem_pkg::axil_w_t)) w_skid_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_data   (s_axil_w),
        .in_valid  (s_axil_wvalid),
        .in_ready  (s_axil_wready),
        .out_data  (w_q),
        .out_valid (w_q_valid),
        .out_ready (w_q_ready)
    );

    axil_skid_buffer #(.payload_t(axil_mem_pkg::axil_ax_t)) ar_skid_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .in_data   (s_axil_ar),
        .in_valid  (s_axil_arvalid),
        .in_ready  (s_axil_arready),
        .out_data  (ar_q),
        .out_valid (ar_q_valid),
        .out_ready (ar_q_ready)
    );

    axil_mem_write write_i (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .aw       (aw_q),
        .aw_valid (aw_q_valid),
        .aw_ready (aw_q_ready),
        .w        (w_q),
        .w_valid  (w_q_valid),
        .w_ready  (w_q_ready),
        .b        (s_axil_b),
        .b_valid  (s_axil_bvalid),
        .b_ready  (s_axil_bready),
        .ram_we   (ram_we),
        .ram_wr   (ram_wr)
    );

    axil_mem_read read_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .ar         (ar_q),
        .ar_valid   (ar_q_valid),
        .ar_ready   (ar_q_ready),
        .r          (s_axil_r),
        .r_valid    (s_axil_rvalid),
        .r_ready    (s_axil_rready),
        .ram_re     (ram_re),
        .ram_rd_idx (ram_rd_idx),
        .ram_rdata  (ram_rdata)
    );

    axil_mem_ram ram_i (
        .aclk       (aclk),
        .ram_we     (ram_we),
        .ram_wr     (ram_wr),
        .ram_re     (ram_re),
        .ram_rd_idx (ram_rd_idx),
        .ram_rdata  (ram_rdata)
    );

endmodule

`default_nettype wire

//--- verilog/axil_mem_write.sv
/* Write unit: pairs AW with W, range-checks the word index,
   drives the RAM write port and returns the B response */

`default_nettype none

module axil_mem_write (
    input  wire logic                   aclk,
    input  wire logic                   aresetn,

    input  wire axil_mem_pkg::axil_ax_t aw,
    input  wire logic                   aw_valid,
    output logic                        aw_ready,

    input  wire axil_mem_pkg::axil_w_t  w,
    input  wire logic                   w_valid,
    output logic                        w_ready,

    output axil_mem_pkg::axil_b_t       b,
    output logic                        b_valid,
    input  wire logic                   b_ready,

    output logic                        ram_we,
    output axil_mem_pkg::ram_wr_t       ram_wr
);

    localparam int WORD_BITS = axil_mem_pkg::ADDR_WIDTH - axil_mem_pkg::BYTE_OFS;

    logic [WORD_BITS-1:0] word_addr;
    logic                 in_range;
    logic                 b_free;
    logic                 fire;

    // Full word address, upper bits take part in the range check
    assign word_addr = aw.addr[axil_mem_pkg::ADDR_WIDTH-1:axil_mem_pkg::BYTE_OFS];
    assign in_range  = (word_addr < WORD_BITS'(axil_mem_pkg::MEM_DEPTH));

    // Response slot is free when empty or being taken this cycle
    assign b_free = ~b_valid | b_ready;

    // Address and data leave together, never one without the other
    assign fire     = aw_valid & w_valid & b_free;
    assign aw_ready = fire;
    assign w_ready  = fire;

    // RAM write on the firing edge, suppressed out of range
    assign ram_we = fire & in_range;

    always_comb begin
        ram_wr.idx  = aw.addr[axil_mem_pkg::BYTE_OFS +: axil_mem_pkg::WORD_AW];
        ram_wr.data = w.data;
        ram_wr.be   = w.strb;
    end

    // Single outstanding write response
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            b_valid <= 1'b0;
        end else if (fire) begin
            b_valid <= 1'b1;
        end else if (b_ready) begin
            b_valid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (fire) begin
            b.resp <= in_range ? axil_mem_pkg::RESP_OKAY
                               : axil_mem_pkg::RESP_SLVERR;
        end
    end

endmodule

`default_nettype wire

//--- verilog/axil_skid_buffer.sv
/* Two-entry registered skid buffer for a valid/ready channel,
   payload type set by parameter */

`default_nettype none

module axil_skid_buffer #(
    parameter type payload_t = logic
) (
    input  wire logic     aclk,
    input  wire logic     aresetn,

    input  wire payload_t in_data,
    input  wire logic     in_valid,
    output logic          in_ready,

    output payload_t      out_data,
    output logic          out_valid,
    input  wire logic     out_ready
);

    payload_t skid_data;
    logic     skid_valid;
    logic     in_fire;
    logic     main_free;

    // Ready comes straight from a flop, no path from out_ready
    assign in_ready  = ~skid_valid;
    assign in_fire   = in_valid & in_ready;
    assign main_free = ~out_valid | out_ready;  // Main entry empties or is empty

    // Control state
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_free) begin
            out_valid  <= skid_valid | in_fire;
            skid_valid <= 1'b0;                   // Skid drains into main first
        end else if (in_fire) begin
            skid_valid <= 1'b1;                   // Main is stuck, park the beat
        end
    end

    // Payload, no reset needed
    always_ff @(posedge aclk) begin
        if (main_free) begin
            out_data <= skid_valid ? skid_data : in_data;
        end
        if (!main_free && in_fire) begin
            skid_data <= in_data;
        end
    end

endmodule

`default_nettype wire
